//--- fp_slice_top.f
+incdir+sim
common/fp_slice_pkg.sv
fp_lane/fp_lane_op.sv
rtl/operand_split.sv
rtl/fp_pipe_regs.sv
rtl/result_pack.sv
rtl/fp_slice_top.sv
sim/tb_fp_slice.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FP slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal \
  -f fp_slice_top.f \
  --top-module tb_fp_slice \
  -Mdir obj_dir -o sim_tb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/sim_tb > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see $SIM_LOG"
  exit 1
fi

if grep -q "TEST FAIL" "$SIM_LOG"; then
  echo "Simulation failed, see $SIM_LOG"
  exit 1
fi

echo "Simulation passed"
exit 0

//--- sim/fp_slice_model.svh
/* Slice reference model
   Computes one lane element and the full packed response of a request */
`ifndef FP_SLICE_MODEL_SVH
`define FP_SLICE_MODEL_SVH

// Lane element result, right-aligned with upper bits zero
function automatic fp_slice_pkg::word_t model_lane(
  input  fp_slice_pkg::word_t      a,
  input  fp_slice_pkg::word_t      b,
  input  fp_slice_pkg::operation_e op,
  input  fp_slice_pkg::fp_format_e fmt,
  output fp_slice_pkg::status_t    st
);
  int unsigned         fw, ew, mw;
  fp_slice_pkg::word_t a_mag, b_mag, a_val, b_val, exp_one, man_msk;
  logic                a_sgn, b_sgn, a_nan, b_nan, sgn, lt;
  logic [32:0]         a_key;
  logic [32:0]         b_key;
  fw      = fp_slice_pkg::fp_width(fmt);
  ew      = fp_slice_pkg::exp_bits(fmt);
  mw      = fp_slice_pkg::man_bits(fmt);
  exp_one = (32'd1 << ew) - 32'd1;
  man_msk = (32'd1 << mw) - 32'd1;
  a_sgn   = a[fw-1];
  b_sgn   = b[fw-1];
  a_mag   = a & ((32'd1 << (fw - 1)) - 32'd1);
  b_mag   = b & ((32'd1 << (fw - 1)) - 32'd1);
  a_val   = a_mag | (fp_slice_pkg::word_t'(a_sgn) << (fw - 1));
  b_val   = b_mag | (fp_slice_pkg::word_t'(b_sgn) << (fw - 1));
  a_nan   = ((a_mag >> mw) == exp_one) && ((a_mag & man_msk) != '0);
  b_nan   = ((b_mag >> mw) == exp_one) && ((b_mag & man_msk) != '0);
  // Order key that puts every negative value below every positive one
  a_key   = a_sgn ? {1'b0, ~a_mag} : {1'b1, a_mag};
  b_key   = b_sgn ? {1'b0, ~b_mag} : {1'b1, b_mag};
  st      = '0;
  case (op)
    fp_slice_pkg::MIN, fp_slice_pkg::MAX: begin
      st.nv = (a_nan && !a[mw-1]) || (b_nan && !b[mw-1]);
      if (a_nan && b_nan) return (exp_one << mw) | (32'd1 << (mw - 1));
      if (a_nan) return b_val;
      if (b_nan) return a_val;
      lt = (a_key < b_key);
      return (lt == (op == fp_slice_pkg::MIN)) ? a_val : b_val;
    end
    fp_slice_pkg::SGNJ:  sgn = b_sgn;
    fp_slice_pkg::SGNJN: sgn = !b_sgn;
    fp_slice_pkg::SGNJX: sgn = a_sgn ^ b_sgn;
    default:             return '0;
  endcase
  return a_mag | (fp_slice_pkg::word_t'(sgn) << (fw - 1));
endfunction

// Full response: lanes placed by format, NaN-box above, masked status
function automatic fp_slice_pkg::slice_rsp_t model_slice(input fp_slice_pkg::slice_req_t req);
  fp_slice_pkg::slice_rsp_t rsp;
  fp_slice_pkg::status_t    st;
  fp_slice_pkg::word_t      mask, elem;
  int unsigned              fw;
  fw   = fp_slice_pkg::fp_width(req.fmt);
  mask = (fw >= fp_slice_pkg::WIDTH) ? '1 : ((32'd1 << fw) - 32'd1);
  rsp  = '{result: '1, status: '0, tag: req.tag};
  for (int unsigned l = 0; l < fp_slice_pkg::NUM_LANES; l++) begin
    if ((l == 0) || (req.vectorial && (l * fw < fp_slice_pkg::WIDTH))) begin
      elem = model_lane(req.operand_a >> (l * fw), req.operand_b >> (l * fw),
                        req.op, req.fmt, st);
      rsp.result = (rsp.result & ~(mask << (l * fw))) | ((elem & mask) << (l * fw));
      if (req.simd_mask[l]) rsp.status = fp_slice_pkg::status_t'(rsp.status | st);
    end
  end
  return rsp;
endfunction

`endif

//--- sim/tb_fp_slice.sv
/* FP slice testbench
   Random requests against the reference model with back-pressure and latency checks */
`timescale 1ns/100ps
`default_nettype none

module tb_fp_slice;

  localparam int unsigned NUM_PIPE_REGS   = 2;
  localparam int unsigned RESET_CYCLES    = 8;
  localparam int unsigned N_SCALAR        = 80;
  localparam int unsigned N_VECTOR        = 80;
  localparam int unsigned N_NAN           = 80;
  localparam int unsigned N_BACKPRESSURE  = 120;
  localparam int unsigned N_LATENCY       = 40;
  localparam int unsigned TOTAL_REQS      = N_SCALAR + N_VECTOR + N_NAN + N_BACKPRESSURE +
                                            N_LATENCY;
  localparam int unsigned WATCHDOG_CYCLES = TOTAL_REQS * 20 + RESET_CYCLES;

  logic                     clk_i = 1'b0;
  logic                     arst_n_i;
  fp_slice_pkg::slice_req_t req_i;
  logic                     in_valid_i, in_ready_o;
  fp_slice_pkg::slice_rsp_t rsp_o;
  logic                     out_valid_o, out_ready_i;

  integer      seed       = 32'h5f7d2b46;
  integer      ready_seed = 32'h5f7d2b46;  // Own stream for the ready driver
  int          errors       = 0;
  int          tests_run    = 0;
  int          tests_passed = 0;
  int unsigned cycle        = 0;
  bit          bp_mode       = 1'b0;  // Random out_ready_i
  bit          check_latency = 1'b0;
  fp_slice_pkg::tag_t       next_tag = '0;
  fp_slice_pkg::slice_rsp_t exp_q[$];
  int unsigned              acc_q[$];  // Accepting cycle of each pending request

  `include "fp_slice_model.svh"

  fp_slice_top #(
    .NumPipeRegs ( NUM_PIPE_REGS )
  ) i_fp_slice_top (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .req_i       ( req_i       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .rsp_o       ( rsp_o       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i )
  );

  always #50 clk_i = ~clk_i;

  // ------------------------------------------------------------------------
  // Compare tasks

  task automatic check_result(input fp_slice_pkg::word_t got, input fp_slice_pkg::word_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch rsp_o.result: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_status(input fp_slice_pkg::status_t got,
                              input fp_slice_pkg::status_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch rsp_o.status: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_tag(input fp_slice_pkg::tag_t got, input fp_slice_pkg::tag_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch rsp_o.tag: got %h expected %h", got, exp);
    end
  endtask

  // ------------------------------------------------------------------------
  // Scoreboard, sampled on the rising edge
  always @(posedge clk_i) begin : monitor
    fp_slice_pkg::slice_rsp_t exp_rsp;
    int unsigned              acc;
    cycle = cycle + 1;
    if (arst_n_i && in_valid_i && in_ready_o) begin
      exp_q.push_back(model_slice(req_i));
      acc_q.push_back(cycle);
    end
    if (arst_n_i && out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Response arrived with no request pending");
      end else begin
        exp_rsp = exp_q.pop_front();
        acc     = acc_q.pop_front();
        check_result(rsp_o.result, exp_rsp.result);
        check_status(rsp_o.status, exp_rsp.status);
        check_tag(rsp_o.tag, exp_rsp.tag);
        if (check_latency && (cycle - acc != NUM_PIPE_REGS)) begin
          errors++;
          $display("Response came %0d cycles after acceptance instead of %0d",
                   cycle - acc, NUM_PIPE_REGS);
        end
      end
    end
  end

  // Downstream ready, held high unless back-pressure is on
  always @(negedge clk_i) begin : ready_drive
    if (bp_mode) begin
      out_ready_i = ({$random(ready_seed)} % 3) != 0;
    end else begin
      out_ready_i = 1'b1;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  // ------------------------------------------------------------------------
  // Stimulus

  // One element, biased towards NaNs, infinities and zeros
  task automatic make_elem(input fp_slice_pkg::fp_format_e fmt, input bit nan_heavy,
                           output fp_slice_pkg::word_t e);
    int unsigned         fw, ew, mw, kind;
    fp_slice_pkg::word_t r, exp_f, low;
    fw    = fp_slice_pkg::fp_width(fmt);
    ew    = fp_slice_pkg::exp_bits(fmt);
    mw    = fp_slice_pkg::man_bits(fmt);
    r     = $random(seed);
    kind  = {$random(seed)} % (nan_heavy ? 5 : 12);
    exp_f = ((32'd1 << ew) - 32'd1) << mw;
    low   = r & ((32'd1 << (mw - 1)) - 32'd1);  // Mantissa below its MSB
    case (kind)
      0:       e = exp_f | (32'd1 << (mw - 1)) | low;  // Quiet NaN
      1:       e = exp_f | low | 32'd1;                // Signaling NaN
      2:       e = '0;
      3:       e = exp_f;                              // Infinity
      default: e = r;
    endcase
    e = (e & ((32'd1 << (fw - 1)) - 32'd1)) | (fp_slice_pkg::word_t'(r[31]) << (fw - 1));
  endtask

  // Upper bits carry noise that the slice must ignore
  task automatic make_operand(input fp_slice_pkg::fp_format_e fmt, input bit vectorial,
                              input bit nan_heavy, output fp_slice_pkg::word_t w);
    fp_slice_pkg::word_t e, mask;
    int unsigned         fw, n;
    fw   = fp_slice_pkg::fp_width(fmt);
    mask = (fw >= 32) ? '1 : ((32'd1 << fw) - 32'd1);
    n    = vectorial ? (fp_slice_pkg::WIDTH / fw) : 1;
    w    = $random(seed);
    for (int unsigned i = 0; i < n; i++) begin
      make_elem(fmt, nan_heavy, e);
      w = (w & ~(mask << (i * fw))) | (e << (i * fw));
    end
  endtask

  // vec_sel 0 gives scalar, 1 vectorial, 2 either
  task automatic make_req(input int vec_sel, input bit nan_heavy,
                          output fp_slice_pkg::slice_req_t r);
    r.fmt       = fp_slice_pkg::fp_format_e'(2'({$random(seed)} % 3));
    r.op        = fp_slice_pkg::operation_e'(3'({$random(seed)} % 5));
    r.vectorial = (vec_sel == 2) ? 1'($random(seed)) : (vec_sel == 1);
    r.simd_mask = 4'($random(seed));
    r.tag       = next_tag;
    next_tag    = next_tag + 8'd1;
    make_operand(r.fmt, r.vectorial, nan_heavy, r.operand_a);
    make_operand(r.fmt, r.vectorial, nan_heavy, r.operand_b);
  endtask

  task automatic send_req(input fp_slice_pkg::slice_req_t r);
    @(negedge clk_i);
    req_i      = r;
    in_valid_i = 1'b1;
    do @(posedge clk_i); while (!in_ready_o);  // Held until accepted
  endtask

  task automatic run_requests(input int unsigned n, input int vec_sel, input bit nan_heavy,
                              input bit gaps);
    fp_slice_pkg::slice_req_t r;
    for (int unsigned i = 0; i < n; i++) begin
      make_req(vec_sel, nan_heavy, r);
      if (gaps && ({$random(seed)} % 4 == 0)) begin
        @(negedge clk_i);
        in_valid_i = 1'b0;  // Idle cycle
      end
      send_req(r);
    end
    @(negedge clk_i);
    in_valid_i = 1'b0;
    while (exp_q.size() != 0) @(posedge clk_i);
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      $display("Test %s: failed with %0d errors", name, errors - err_start);
    end
  endtask

  // ------------------------------------------------------------------------
  // Test sequence
  initial begin : main
    int err_start;
    arst_n_i    = 1'b0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    req_i       = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    err_start = errors;
    @(posedge clk_i);
    if (out_valid_o !== 1'b0) begin
      errors++;
      $display("out_valid_o is not low right after reset");
    end
    if (in_ready_o !== 1'b1) begin
      errors++;
      $display("in_ready_o is not high right after reset");
    end
    finish_test("reset_idle", err_start);

    err_start = errors;
    run_requests(N_SCALAR, 0, 1'b0, 1'b1);
    finish_test("scalar", err_start);

    err_start = errors;
    run_requests(N_VECTOR, 1, 1'b0, 1'b1);
    finish_test("vectorial", err_start);

    err_start = errors;
    run_requests(N_NAN, 2, 1'b1, 1'b1);
    finish_test("nan_status", err_start);

    err_start = errors;
    bp_mode   = 1'b1;
    run_requests(N_BACKPRESSURE, 2, 1'b0, 1'b1);
    bp_mode   = 1'b0;
    finish_test("backpressure", err_start);

    err_start     = errors;
    check_latency = 1'b1;
    run_requests(N_LATENCY, 2, 1'b0, 1'b0);
    check_latency = 1'b0;
    finish_test("latency", err_start);

    $display("Tests passed: %0d of %0d, errors: %0d", tests_passed, tests_run, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/fp_slice_top.sv
/* FP slice top level
   Splits the request into lanes, runs the lane units and pipelines the packed result */
`timescale 1ns/100ps
`default_nettype none

module fp_slice_top #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  fp_slice_pkg::slice_req_t req_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  output fp_slice_pkg::slice_rsp_t rsp_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i
);

  fp_slice_pkg::word_t   [fp_slice_pkg::NUM_LANES-1:0] lane_a;
  fp_slice_pkg::word_t   [fp_slice_pkg::NUM_LANES-1:0] lane_b;
  fp_slice_pkg::word_t   [fp_slice_pkg::NUM_LANES-1:0] lane_result;
  fp_slice_pkg::status_t [fp_slice_pkg::NUM_LANES-1:0] lane_status;
  fp_slice_pkg::lane_mask_t                            lane_active;
  fp_slice_pkg::lane_bundle_t                          pipe_in, pipe_out;

  operand_split i_operand_split (
    .req_i         ( req_i       ),
    .lane_a_o      ( lane_a      ),
    .lane_b_o      ( lane_b      ),
    .lane_active_o ( lane_active )
  );

  // Lane widths shrink with the lane index: 32, 16, 8, 8
  for (genvar lane = 0; lane < int'(fp_slice_pkg::NUM_LANES); lane++) begin : gen_lanes
    localparam int unsigned LANE_W = fp_slice_pkg::lane_width(unsigned'(lane));

    logic [LANE_W-1:0] lane_res;

    fp_lane_op #(
      .LaneWidth ( LANE_W )
    ) i_fp_lane_op (
      .a_i      ( lane_a[lane][LANE_W-1:0] ),
      .b_i      ( lane_b[lane][LANE_W-1:0] ),
      .op_i     ( req_i.op                 ),
      .fmt_i    ( req_i.fmt                ),
      .result_o ( lane_res                 ),
      .status_o ( lane_status[lane]        )
    );

    assign lane_result[lane] = fp_slice_pkg::word_t'(lane_res);
  end

  assign pipe_in = '{lane_result: lane_result,
                     lane_status: lane_status,
                     lane_active: lane_active,
                     simd_mask:   req_i.simd_mask,
                     fmt:         req_i.fmt,
                     vectorial:   req_i.vectorial,
                     tag:         req_i.tag};

  fp_pipe_regs #(
    .NumPipeRegs ( NumPipeRegs )
  ) i_fp_pipe_regs (
    .clk_i    ( clk_i       ),
    .arst_n_i ( arst_n_i    ),
    .data_i   ( pipe_in     ),
    .valid_i  ( in_valid_i  ),
    .ready_o  ( in_ready_o  ),
    .data_o   ( pipe_out    ),
    .valid_o  ( out_valid_o ),
    .ready_i  ( out_ready_i )
  );

  result_pack i_result_pack (
    .bundle_i ( pipe_out ),
    .rsp_o    ( rsp_o    )
  );

endmodule

`default_nettype wire

//--- rtl/result_pack.sv
/* Result packing
   Places lane results in the 32-bit word, NaN-boxes the rest and merges status */
`timescale 1ns/100ps
`default_nettype none

module result_pack (
  input  fp_slice_pkg::lane_bundle_t bundle_i,
  output fp_slice_pkg::slice_rsp_t   rsp_o
);

  int unsigned           fmt_w;     // Element width of the bundle format
  fp_slice_pkg::word_t   fmt_mask;  // Low fmt_w bits set
  fp_slice_pkg::word_t   result;
  fp_slice_pkg::status_t status;

  assign fmt_w    = fp_slice_pkg::fp_width(bundle_i.fmt);
  assign fmt_mask = (fmt_w >= fp_slice_pkg::WIDTH) ? '1 :
                    ((fp_slice_pkg::word_t'(1) << fmt_w) - fp_slice_pkg::word_t'(1));

  // ---------------------------------------------------------------------------
  // Lane placement and status collapse
  always_comb begin : pack_lanes
    result = '1;  // Unused bits stay NaN-boxed
    status = '0;
    for (int unsigned lane = 0; lane < fp_slice_pkg::NUM_LANES; lane++) begin
      if (bundle_i.lane_active[lane]) begin
        result = (result & ~(fmt_mask << (lane * fmt_w))) |
                 ((bundle_i.lane_result[lane] & fmt_mask) << (lane * fmt_w));
        // Masked-off lanes keep their result but drop their flags
        if (bundle_i.simd_mask[lane]) begin
          status = fp_slice_pkg::status_t'(status | bundle_i.lane_status[lane]);
        end
      end
    end
  end

  assign rsp_o = '{result: result, status: status, tag: bundle_i.tag};

endmodule

`default_nettype wire

//--- rtl/fp_pipe_regs.sv
/* Pipeline registers
   Chain of valid/ready stages carrying the lane bundle */
`timescale 1ns/100ps
`default_nettype none

module fp_pipe_regs #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  fp_slice_pkg::lane_bundle_t data_i,
  input  logic                       valid_i,
  output logic                       ready_o,
  output fp_slice_pkg::lane_bundle_t data_o,
  output logic                       valid_o,
  input  logic                       ready_i
);

  // Index i holds the state after i stages, index 0 is the input side
  fp_slice_pkg::lane_bundle_t stage_data [0:NumPipeRegs];
  logic [0:NumPipeRegs]       stage_valid;
  logic [0:NumPipeRegs]       stage_ready;

  assign stage_data[0]  = data_i;
  assign stage_valid[0] = valid_i;

  for (genvar i = 0; i < int'(NumPipeRegs); i++) begin : gen_stages
    logic load;  // Payload moves into stage i+1

    // Accept when the next stage drains or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];
    assign load           = stage_ready[i] & stage_valid[i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin : valid_reg
      if (!arst_n_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin : data_reg
      if (load) begin
        stage_data[i+1] <= stage_data[i];
      end
    end
  end

  // Ready travels back from the downstream side
  assign stage_ready[NumPipeRegs] = ready_i;
  assign ready_o                  = stage_ready[0];
  assign data_o                   = stage_data[NumPipeRegs];
  assign valid_o                  = stage_valid[NumPipeRegs];

endmodule

`default_nettype wire

//--- rtl/operand_split.sv
/* Operand split
   Cuts both operands into right-aligned lane elements and marks the lanes in use */
`timescale 1ns/100ps
`default_nettype none

module operand_split (
  input  fp_slice_pkg::slice_req_t                          req_i,
  output fp_slice_pkg::word_t [fp_slice_pkg::NUM_LANES-1:0] lane_a_o,
  output fp_slice_pkg::word_t [fp_slice_pkg::NUM_LANES-1:0] lane_b_o,
  output fp_slice_pkg::lane_mask_t                          lane_active_o
);

  int unsigned fmt_w;  // Element width of the request format

  assign fmt_w = fp_slice_pkg::fp_width(req_i.fmt);

  always_comb begin : split_lanes
    for (int unsigned lane = 0; lane < fp_slice_pkg::NUM_LANES; lane++) begin
      // Upper bits are left for the lane unit to ignore
      lane_a_o[lane] = req_i.operand_a >> (lane * fmt_w);
      lane_b_o[lane] = req_i.operand_b >> (lane * fmt_w);

      // Lane 0 always runs, upper lanes only for vectors that reach them
      lane_active_o[lane] = (lane == 0) ||
                            (req_i.vectorial && (lane * fmt_w < fp_slice_pkg::WIDTH));
    end
  end

endmodule

`default_nettype wire

//--- fp_lane/fp_lane_op.sv
/* FP lane operation
   Min/max and sign injection on one lane element with NaN handling and the NV flag */
`timescale 1ns/100ps
`default_nettype none

module fp_lane_op #(
  parameter int unsigned LaneWidth = 32
) (
  input  logic [LaneWidth-1:0]     a_i,
  input  logic [LaneWidth-1:0]     b_i,
  input  fp_slice_pkg::operation_e op_i,
  input  fp_slice_pkg::fp_format_e fmt_i,
  output logic [LaneWidth-1:0]     result_o,
  output fp_slice_pkg::status_t    status_o
);

  // Decoded operand, the magnitude holds exponent and mantissa
  typedef struct packed {
    logic                 sign;
    logic [LaneWidth-1:0] mag;
    logic                 is_nan;
    logic                 is_snan;
  } fp_class_t;

  int unsigned           fmt_w, exp_w, man_w;
  logic                  fmt_fits;   // Format fits this lane
  logic [LaneWidth-1:0]  sign_bit;   // One-hot sign position
  logic [LaneWidth-1:0]  canon_nan;
  logic [LaneWidth-1:0]  a_val, b_val, res;
  fp_class_t             a_cls, b_cls;
  logic                  a_lt_b, inj_sign;
  fp_slice_pkg::status_t status;

  function automatic fp_class_t classify(
    input logic [LaneWidth-1:0] x,
    input int unsigned          fw,
    input int unsigned          ew,
    input int unsigned          mw
  );
    fp_class_t            c;
    logic [LaneWidth-1:0] exp_ones, man_f, sign_sh, quiet_sh;
    exp_ones  = (LaneWidth'(1) << ew) - LaneWidth'(1);
    man_f     = x & ((LaneWidth'(1) << mw) - LaneWidth'(1));
    sign_sh   = x >> (fw - 1);
    quiet_sh  = man_f >> (mw - 1);  // Mantissa MSB marks a quiet NaN
    c.sign    = sign_sh[0];
    c.mag     = x & ((LaneWidth'(1) << (fw - 1)) - LaneWidth'(1));
    c.is_nan  = ((c.mag >> mw) == exp_ones) && (man_f != '0);
    c.is_snan = c.is_nan && !quiet_sh[0];
    return c;
  endfunction

  // ---------------------------------------------------------------------------
  // Decode
  assign fmt_w    = fp_slice_pkg::fp_width(fmt_i);
  assign exp_w    = fp_slice_pkg::exp_bits(fmt_i);
  assign man_w    = fp_slice_pkg::man_bits(fmt_i);
  assign fmt_fits = (fmt_w <= LaneWidth);
  assign sign_bit = LaneWidth'(1) << (fmt_w - 1);

  // Positive sign, exponent all ones, mantissa MSB set
  assign canon_nan = (((LaneWidth'(1) << exp_w) - LaneWidth'(1)) << man_w) |
                     (LaneWidth'(1) << (man_w - 1));

  assign a_cls = classify(a_i, fmt_w, exp_w, man_w);
  assign b_cls = classify(b_i, fmt_w, exp_w, man_w);
  assign a_val = a_cls.mag | (a_cls.sign ? sign_bit : '0);
  assign b_val = b_cls.mag | (b_cls.sign ? sign_bit : '0);

  // Sign-magnitude order, -0 sorts below +0
  assign a_lt_b = (a_cls.sign != b_cls.sign) ? a_cls.sign :
                  (a_cls.sign ? (a_cls.mag > b_cls.mag) : (a_cls.mag < b_cls.mag));

  // ---------------------------------------------------------------------------
  // Operation
  always_comb begin : lane_op
    res      = '0;
    status   = '0;
    inj_sign = 1'b0;
    case (op_i)
      fp_slice_pkg::MIN, fp_slice_pkg::MAX: begin
        status.nv = a_cls.is_snan | b_cls.is_snan;
        if (a_cls.is_nan && b_cls.is_nan) begin
          res = canon_nan;
        end else if (a_cls.is_nan) begin
          res = b_val;                          // NaN loses to a number
        end else if (b_cls.is_nan) begin
          res = a_val;
        end else begin
          res = ((op_i == fp_slice_pkg::MIN) == a_lt_b) ? a_val : b_val;
        end
      end
      fp_slice_pkg::SGNJ, fp_slice_pkg::SGNJN, fp_slice_pkg::SGNJX: begin
        case (op_i)
          fp_slice_pkg::SGNJ:  inj_sign = b_cls.sign;
          fp_slice_pkg::SGNJN: inj_sign = ~b_cls.sign;
          default:             inj_sign = a_cls.sign ^ b_cls.sign;
        endcase
        res = a_cls.mag | (inj_sign ? sign_bit : '0);
      end
      default: ;
    endcase
  end

  // Formats wider than the lane never reach it as active
  assign result_o = fmt_fits ? res : '0;
  assign status_o = fmt_fits ? status : '0;

endmodule

`default_nettype wire

//--- common/fp_slice_pkg.sv
/* FP slice package
   Formats, operations, status flags and the bundles carried through the slice */
`default_nettype none

package fp_slice_pkg;

  localparam int unsigned WIDTH     = 32;
  localparam int unsigned NUM_LANES = 4;  // WIDTH over the narrowest format

  typedef logic [WIDTH-1:0] word_t;

  typedef enum logic [1:0] {
    FP32 = 2'd0,  // e8m23
    FP16 = 2'd1,  // e5m10
    FP8  = 2'd2   // e5m2
  } fp_format_e;

  typedef enum logic [2:0] {
    MIN   = 3'd0,
    MAX   = 3'd1,
    SGNJ  = 3'd2,
    SGNJN = 3'd3,
    SGNJX = 3'd4
  } operation_e;

  // ---------------------------------------------------------------------------
  // Format geometry

  function automatic int unsigned fp_width(fp_format_e fmt);
    case (fmt)
      FP16:    return 16;
      FP8:     return 8;
      default: return 32;
    endcase
  endfunction

  function automatic int unsigned exp_bits(fp_format_e fmt);
    return (fmt == FP32) ? 8 : 5;
  endfunction

  function automatic int unsigned man_bits(fp_format_e fmt);
    case (fmt)
      FP16:    return 10;
      FP8:     return 2;
      default: return 23;
    endcase
  endfunction

  // Widest format that still has an element in this lane
  function automatic int unsigned lane_width(int unsigned lane);
    if (lane * fp_width(FP32) < WIDTH) return fp_width(FP32);
    if (lane * fp_width(FP16) < WIDTH) return fp_width(FP16);
    return fp_width(FP8);
  endfunction

  // ---------------------------------------------------------------------------
  // Bundles

  typedef struct packed {
    logic nv;  // Invalid operation, the only flag this group raises
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  typedef logic [7:0]           tag_t;
  typedef logic [NUM_LANES-1:0] lane_mask_t;

  typedef struct packed {
    word_t      operand_a;
    word_t      operand_b;
    operation_e op;
    fp_format_e fmt;
    logic       vectorial;
    tag_t       tag;
    lane_mask_t simd_mask;
  } slice_req_t;

  typedef struct packed {
    word_t   [NUM_LANES-1:0] lane_result;  // Right-aligned per lane
    status_t [NUM_LANES-1:0] lane_status;
    lane_mask_t              lane_active;
    lane_mask_t              simd_mask;
    fp_format_e              fmt;
    logic                    vectorial;
    tag_t                    tag;
  } lane_bundle_t;

  typedef struct packed {
    word_t   result;
    status_t status;
    tag_t    tag;
  } slice_rsp_t;

endpackage

`default_nettype wire
